/* common/video_pkg.sv */
package video_pkg;

	// **************************************************
	// register data and addresses
	// **************************************************

	typedef logic [7:0] reg_byte_t;	// one cpu-visible register

	// low address byte, high byte is always ff
	typedef enum logic [7:0] {
		addr_lcdc = 8'h40,
		addr_scy  = 8'h42,
		addr_scx  = 8'h43,
		addr_ly   = 8'h44,
		addr_lyc  = 8'h45,
		addr_wy   = 8'h4A,
		addr_wx   = 8'h4B
	} reg_addr_e;

	// one select bit per register, same order as reg_addr_e
	typedef struct packed {
		logic lcdc;
		logic scy;
		logic scx;
		logic ly;
		logic lyc;
		logic wy;
		logic wx;
	} reg_sel_t;

	localparam reg_byte_t UNMAPPED_DATA = 8'hFF;	// open bus value

	// **************************************************
	// lcdc
	// **************************************************

	localparam int        LCDC_ENABLE_BIT = 7;
	localparam reg_byte_t LCDC_RESET      = 8'h91;	// display on, bg on, tile data 8000

	// **************************************************
	// scan timing
	// **************************************************

	localparam int DOTS_PER_LINE   = 456;
	localparam int LINES_PER_FRAME = 154;	// 144 visible + 10 vblank

	localparam int DOT_W = $clog2(DOTS_PER_LINE);
	typedef logic [DOT_W-1:0] dot_cnt_t;

endpackage

/* common/cpu_bus_if.sv */
`timescale 1ns/1ps

// decoded register access, decoder side to register file side
interface cpu_bus_if;
	import video_pkg::*;

	reg_sel_t  sel;		// one-hot, or all zero when unmapped
	logic      wr;
	logic      rd;
	reg_byte_t wdata;
	reg_byte_t rdata;	// combinational from the register file

	modport decoder (
		output sel,
		output wr,
		output rd,
		output wdata,
		input  rdata
	);

	modport regs (
		input  sel,
		input  wr,
		input  rd,
		input  wdata,
		output rdata
	);

endinterface

/* source/bus_decode.sv */
`timescale 1ns/1ps

module bus_decode (
	input  logic                  clk,
	input  logic                  rst,
	input  video_pkg::reg_addr_e  addr,
	input  logic                  rd,
	input  logic                  wr,
	input  video_pkg::reg_byte_t  wdata,
	output video_pkg::reg_byte_t  rdata,
	cpu_bus_if.decoder            bus
);
	import video_pkg::*;

	reg_sel_t sel;
	logic     hit;

	// **************************************************
	// address match
	// **************************************************

	always_comb begin
		sel = '0;
		case (addr)
			addr_lcdc: sel.lcdc = 1'b1;
			addr_scy:  sel.scy  = 1'b1;
			addr_scx:  sel.scx  = 1'b1;
			addr_ly:   sel.ly   = 1'b1;
			addr_lyc:  sel.lyc  = 1'b1;
			addr_wy:   sel.wy   = 1'b1;
			addr_wx:   sel.wx   = 1'b1;
			default:   sel = '0;	// nothing in this block answers
		endcase
	end

	assign hit = |sel;

	// strobes and data go straight to the register file
	assign bus.sel   = sel;
	assign bus.wr    = wr;
	assign bus.rd    = rd;
	assign bus.wdata = wdata;

	// **************************************************
	// read data register
	// **************************************************

	// holds until the next rd strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			rdata <= '0;
		end else if (rd) begin
			if (hit)
				rdata <= bus.rdata;
			else
				rdata <= UNMAPPED_DATA;
		end
	end

endmodule

/* video_regs/video_regs.sv */
`timescale 1ns/1ps

module video_regs (
	input  logic                  clk,
	input  logic                  rst,
	cpu_bus_if.regs               bus,
	input  video_pkg::reg_byte_t  ly,
	output video_pkg::reg_byte_t  lcdc,
	output video_pkg::reg_byte_t  scy,
	output video_pkg::reg_byte_t  scx,
	output video_pkg::reg_byte_t  lyc,
	output video_pkg::reg_byte_t  wy,
	output video_pkg::reg_byte_t  wx
);
	import video_pkg::*;

	logic      wr_lcdc;
	logic      wr_scy;
	logic      wr_scx;
	logic      wr_lyc;
	logic      wr_wy;
	logic      wr_wx;
	reg_byte_t rd_mux;

	// **************************************************
	// write enables
	// **************************************************

	assign wr_lcdc = bus.wr && bus.sel.lcdc;
	assign wr_scy  = bus.wr && bus.sel.scy;
	assign wr_scx  = bus.wr && bus.sel.scx;
	assign wr_lyc  = bus.wr && bus.sel.lyc;
	assign wr_wy   = bus.wr && bus.sel.wy;
	assign wr_wx   = bus.wr && bus.sel.wx;
	// sel.ly has no write enable, ly belongs to the line counter

	// **************************************************
	// storage
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			lcdc <= LCDC_RESET;
		end else if (wr_lcdc) begin
			lcdc <= bus.wdata;
		end
	end

	// scroll position
	always_ff @(posedge clk) begin
		if (rst) begin
			scy <= '0;
			scx <= '0;
		end else begin
			if (wr_scy)
				scy <= bus.wdata;
			if (wr_scx)
				scx <= bus.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lyc <= '0;
		end else if (wr_lyc) begin
			lyc <= bus.wdata;	// compare value for the line counter
		end
	end

	// window position
	always_ff @(posedge clk) begin
		if (rst) begin
			wy <= '0;
			wx <= '0;
		end else begin
			if (wr_wy)
				wy <= bus.wdata;
			if (wr_wx)
				wx <= bus.wdata;
		end
	end

	// **************************************************
	// read mux
	// **************************************************

	// and-or over the one-hot select, zero when nothing is selected
	always_comb begin
		rd_mux = ({8{bus.sel.lcdc}} & lcdc)
		       | ({8{bus.sel.scy}}  & scy)
		       | ({8{bus.sel.scx}}  & scx)
		       | ({8{bus.sel.ly}}   & ly)
		       | ({8{bus.sel.lyc}}  & lyc)
		       | ({8{bus.sel.wy}}   & wy)
		       | ({8{bus.sel.wx}}   & wx);
	end

	assign bus.rdata = bus.rd ? rd_mux : '0;	// only drive data during a read

endmodule

/* video_regs/line_counter.sv */
`timescale 1ns/1ps

module line_counter (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  lcd_on,
	input  video_pkg::reg_byte_t  lyc,
	output video_pkg::reg_byte_t  ly,
	output logic                  lyc_match_pulse
);
	import video_pkg::*;

	dot_cnt_t dot;
	logic     line_end;
	logic     frame_end;
	logic     ly_stepped;	// ly took a new value on the last edge

	assign line_end  = (dot == dot_cnt_t'(DOTS_PER_LINE - 1));
	assign frame_end = (ly == reg_byte_t'(LINES_PER_FRAME - 1));

	// **************************************************
	// dot and line counters
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			dot <= '0;
		end else if (!lcd_on) begin
			dot <= '0;	// held while the display is off
		end else if (line_end) begin
			dot <= '0;
		end else begin
			dot <= dot + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ly         <= '0;
			ly_stepped <= 1'b0;
		end else if (!lcd_on) begin
			ly         <= '0;
			ly_stepped <= 1'b0;
		end else begin
			ly_stepped <= line_end;
			if (line_end) begin
				if (frame_end)
					ly <= '0;	// back to the top after vblank
				else
					ly <= ly + 1'b1;
			end
		end
	end

	// **************************************************
	// coincidence
	// **************************************************

	// compared one cycle after the step, so a lyc write alone never fires
	always_ff @(posedge clk) begin
		if (rst) begin
			lyc_match_pulse <= 1'b0;
		end else begin
			lyc_match_pulse <= lcd_on && ly_stepped && (ly == lyc);
		end
	end

endmodule

/* source/lcd_io_top.sv */
`timescale 1ns/1ps

module lcd_io_top (
	input  logic                  clk,
	input  logic                  rst,

	// cpu side
	input  logic [7:0]            addr,
	input  logic                  rd,
	input  logic                  wr,
	input  video_pkg::reg_byte_t  wdata,
	output video_pkg::reg_byte_t  rdata,

	// to the video core
	output video_pkg::reg_byte_t  lcdc,
	output video_pkg::reg_byte_t  scy,
	output video_pkg::reg_byte_t  scx,
	output video_pkg::reg_byte_t  wy,
	output video_pkg::reg_byte_t  wx,
	output video_pkg::reg_byte_t  ly,
	output logic                  lyc_irq
);
	import video_pkg::*;

	reg_byte_t lyc;
	logic      lcd_on;

	cpu_bus_if u_bus ();

	assign lcd_on = lcdc[LCDC_ENABLE_BIT];

	bus_decode u_bus_decode (
		.clk   (clk),
		.rst   (rst),
		.addr  (reg_addr_e'(addr)),	// unmapped codes fall to the default
		.rd    (rd),
		.wr    (wr),
		.wdata (wdata),
		.rdata (rdata),
		.bus   (u_bus.decoder)
	);

	video_regs u_video_regs (
		.clk  (clk),
		.rst  (rst),
		.bus  (u_bus.regs),
		.ly   (ly),
		.lcdc (lcdc),
		.scy  (scy),
		.scx  (scx),
		.lyc  (lyc),
		.wy   (wy),
		.wx   (wx)
	);

	line_counter u_line_counter (
		.clk             (clk),
		.rst             (rst),
		.lcd_on          (lcd_on),
		.lyc             (lyc),
		.ly              (ly),
		.lyc_match_pulse (lyc_irq)
	);

endmodule

/* testbench/lcd_io_checker.sv */
`timescale 1ns/1ps

module lcd_io_checker (
	input logic                  clk,
	input logic                  rst,
	input logic                  rd,
	input logic                  wr,
	input video_pkg::reg_byte_t  lcdc,
	input video_pkg::reg_byte_t  ly,
	input logic                  lyc_irq
);
	import video_pkg::*;

	rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst) !(rd && wr))
		else $error("rd and wr high in the same cycle");

	// coincidence strobe lasts one cycle
	irq_single_cycle: assert property (@(posedge clk) disable iff (rst) lyc_irq |=> !lyc_irq)
		else $error("lyc_irq high on two consecutive cycles");

	ly_in_frame: assert property (@(posedge clk) disable iff (rst)
		ly < reg_byte_t'(LINES_PER_FRAME))
		else $error("ly beyond the last line");

	ly_held_when_off: assert property (@(posedge clk) disable iff (rst)
		!lcdc[LCDC_ENABLE_BIT] |=> (ly == '0))
		else $error("ly not zero after the display was off");

endmodule

bind lcd_io_top lcd_io_checker u_lcd_io_checker (
	.clk     (clk),
	.rst     (rst),
	.rd      (rd),
	.wr      (wr),
	.lcdc    (lcdc),
	.ly      (ly),
	.lyc_irq (lyc_irq)
);

/* testbench/tb_lcd_io.sv */
`timescale 1ns/1ps

module tb_lcd_io;
	import video_pkg::*;

	localparam int         MAX_RECS    = 64;
	localparam logic [3:0] OP_WRITE    = 4'h0;
	localparam logic [3:0] OP_READ     = 4'h1;
	localparam logic [3:0] OP_WAIT_LY  = 4'h2;
	localparam logic [3:0] OP_WAIT_IRQ = 4'h3;
	localparam logic [3:0] OP_END      = 4'hF;

	logic       clk;
	logic       rst;
	logic [7:0] addr;
	logic       rd;
	logic       wr;
	reg_byte_t  wdata;
	reg_byte_t  rdata;
	reg_byte_t  lcdc;
	reg_byte_t  scy;
	reg_byte_t  scx;
	reg_byte_t  wy;
	reg_byte_t  wx;
	reg_byte_t  ly;
	logic       lyc_irq;

	logic [31:0] recs [MAX_RECS];	// op, addr, data, count
	reg_byte_t   model [256];	// last random value written per address
	logic [31:0] lfsr;
	int          limit_cycles;
	logic        limit_ready;

	lcd_io_top u_lcd_io_top (
		.clk     (clk),
		.rst     (rst),
		.addr    (addr),
		.rd      (rd),
		.wr      (wr),
		.wdata   (wdata),
		.rdata   (rdata),
		.lcdc    (lcdc),
		.scy     (scy),
		.scx     (scx),
		.wy      (wy),
		.wx      (wx),
		.ly      (ly),
		.lyc_irq (lyc_irq)
	);

	always #10 clk = ~clk;

	// **************************************************
	// helpers
	// **************************************************

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_byte(input string name, input reg_byte_t expected,
			input reg_byte_t actual);
		if (actual !== expected)
			stop_with_failure($sformatf("[ERROR] %s expected %02h actual %02h",
				name, expected, actual));
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected)
			stop_with_failure($sformatf("[ERROR] %s expected %0d actual %0d",
				name, expected, actual));
	endtask

	// galois form, polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	task automatic next_random_byte(output reg_byte_t b);
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr[0];	// one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// all bus tasks start and end on a falling edge
	task automatic bus_write(input logic [7:0] a, input reg_byte_t d);
		addr  = a;
		wdata = d;
		wr    = 1'b1;
		@(negedge clk);
		wr = 1'b0;
	endtask

	task automatic bus_read(input logic [7:0] a, output reg_byte_t d);
		addr = a;
		rd   = 1'b1;
		@(negedge clk);
		rd = 1'b0;
		d  = rdata;
	endtask

	task automatic count_irq(input int lines, output int pulses);
		pulses = 0;
		repeat (lines * DOTS_PER_LINE) begin
			@(negedge clk);
			if (lyc_irq)
				pulses++;
		end
	endtask

	function automatic reg_byte_t port_value(input logic [7:0] a);
		case (a)
			addr_lcdc: return lcdc;
			addr_scy:  return scy;
			addr_scx:  return scx;
			addr_ly:   return ly;
			addr_wy:   return wy;
			addr_wx:   return wx;
			default:   return '0;
		endcase
	endfunction

	// **************************************************
	// watchdog
	// **************************************************

	initial begin
		wait (limit_ready);
		repeat (limit_cycles) @(posedge clk);
		stop_with_failure($sformatf("timeout, stimulus not done after %0d cycles", limit_cycles));
	end

	// **************************************************
	// stimulus
	// **************************************************

	initial begin
		logic [31:0] rec;
		logic [3:0]  op;
		logic [7:0]  a;
		reg_byte_t   d;
		reg_byte_t   got;
		int          cnt;
		int          pulses;
		int          idx;
		string       name;

		clk         = 1'b0;
		rst         = 1'b1;
		addr        = '0;
		rd          = 1'b0;
		wr          = 1'b0;
		wdata       = '0;
		lfsr        = 32'h8c3c0b29;
		limit_ready = 1'b0;
		for (int i = 0; i < MAX_RECS; i++)
			recs[i] = {OP_END, 28'h0};
		for (int i = 0; i < 256; i++)
			model[i] = '0;
		$readmemh("testbench/lcd_io_input.txt", recs);

		// run length from the records, plus reset and margin
		limit_cycles = 5 + 1000;
		for (int i = 0; i < MAX_RECS && recs[i][31:28] != OP_END; i++) begin
			if (recs[i][31:28] == OP_WAIT_LY)
				limit_cycles += int'(recs[i][11:0]) * DOTS_PER_LINE + 200;
			else if (recs[i][31:28] == OP_WAIT_IRQ)
				limit_cycles += int'(recs[i][11:0]) * DOTS_PER_LINE;
			else
				limit_cycles += 1;
		end
		limit_ready = 1'b1;

		repeat (5) @(negedge clk);
		rst = 1'b0;
		check_byte("reset rdata", '0, rdata);
		check_count("reset lyc_irq", 0, int'(lyc_irq));

		idx = 0;
		while (idx < MAX_RECS && recs[idx][31:28] != OP_END) begin
			rec  = recs[idx];
			op   = rec[31:28];
			a    = rec[27:20];
			d    = rec[19:12];
			cnt  = int'(rec[11:0]);
			name = $sformatf("record %0d op %0h ff%02h", idx, op, a);
			case (op)
				OP_WRITE: begin
					if (cnt != 0) begin
						next_random_byte(d);
						model[a] = d;
					end
					bus_write(a, d);
				end
				OP_READ: begin
					bus_read(a, got);
					if (cnt != 0) begin
						check_byte(name, model[a], got);
						if (a != addr_lyc)	// lyc has no port
							check_byte({name, " port"}, model[a], port_value(a));
					end else begin
						check_byte(name, d, got);
					end
				end
				OP_WAIT_LY: begin
					repeat (cnt * DOTS_PER_LINE + 200) @(negedge clk);
					check_byte(name, d, ly);
				end
				OP_WAIT_IRQ: begin
					count_irq(cnt, pulses);
					check_count(name, int'(d), pulses);
				end
				default: stop_with_failure($sformatf("unknown opcode %0h in record %0d", op, idx));
			endcase
			idx++;
		end

		if (idx == 0) begin
			stop_with_failure("the stimulus file held no records");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

/* testbench/lcd_io_input.txt */
// op_addr_data_count; op 0 write, 1 read and expect, 2 wait count lines then expect ly, 3 wait count lines and expect irq pulses
// on a write or read a count of 1 takes lfsr data and checks against the model, data on a wait is the expected value
1_40_91_000 // reset values
1_42_00_000
1_43_00_000
1_45_00_000
1_4A_00_000
1_4B_00_000
0_40_00_001 // random sweep
1_40_00_001
0_40_11_000
0_42_00_001
0_43_00_001
0_45_00_001
0_4A_00_001
0_4B_00_001
1_42_00_001
1_43_00_001
1_45_00_001
1_4A_00_001
1_4B_00_001
0_44_5A_000 // ly is read only
1_44_00_000
1_50_FF_000 // unmapped
1_FF_FF_000
0_40_91_000 // line counting
2_00_02_002
0_45_02_000
3_00_00_001
0_40_11_000
0_40_91_000
2_00_01_09B
0_40_11_000 // display off
2_00_00_003
1_44_00_000
0_45_0A_000 // one pulse per frame
0_40_91_000
3_00_01_09A
3_00_01_09A
F_00_00_000

/* src.f */
common/video_pkg.sv
common/cpu_bus_if.sv
source/bus_decode.sv
video_regs/video_regs.sv
video_regs/line_counter.sv
source/lcd_io_top.sv
testbench/lcd_io_checker.sv
testbench/tb_lcd_io.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_lcd_io -f src.f \
	&& ./obj_dir/Vtb_lcd_io > sim.log 2>&1 \
	|| echo "build or simulation error" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0
